// File: project.f
verilog/cpuPkg.sv
verilog/ctrlIf.sv
verilog/controlFsm.sv
verilog/registerFile.sv
verilog/aluFlags.sv
verilog/busDatapath.sv
verilog/cpuTop.sv
verif/clockGen.sv
verif/tbCpu.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - files:
      - verilog/cpuPkg.sv
      - verilog/ctrlIf.sv
      - verilog/controlFsm.sv
      - verilog/registerFile.sv
      - verilog/aluFlags.sv
      - verilog/busDatapath.sv
      - verilog/cpuTop.sv
  - target: test
    files:
      - verif/clockGen.sv
      - verif/tbCpu.sv

// File: verif/tbCpu.sv
`timescale 1ns/100ps
`default_nettype none

module tbCpu import cpuPkg::*; ();

    localparam int   resetCycles   = 16;
    localparam int   idleCycles    = 40;      // Run held low after the first reset
    localparam int   maxSteps      = 2000;    // guard for the reference model
    localparam int   quarterPeriod = 25;
    localparam wordT dataBase      = 16'h0080;  // words preloaded for ld
    localparam wordT storeBase     = 16'h00C0;  // st targets

    logic        Clock;
    logic        arstN;
    logic        resetReq = 1'b0;
    logic        Run      = 1'b0;
    wordT        DIN      = '0;
    wordT        ADDR;
    wordT        DOUT;
    logic        W;

    wordT        mem [0:255];          // program and data
    logic [7:0]  readAddr = '0;        // address the memory took last cycle
    wordT        expAddr [$];          // pending stores in order
    wordT        expData [$];
    logic [31:0] rngState   = 32'd50;
    int          progLen    = 0;
    int          haltAddr   = 0;
    int          cycleCount = 0;
    int          cycleLimit = resetCycles + idleCycles + 2;
    int          checkCount = 0;
    int          errorCount = 0;
    int          testCount  = 0;
    logic        wPrev      = 1'b0;

    clockGen #(.resetCycles(resetCycles)) uClk (
        .resetReq (resetReq),
        .Clock    (Clock),
        .arstN    (arstN)
    );

    cpuTop u_dut (
        .Clock (Clock),
        .arstN (arstN),
        .Run   (Run),
        .DIN   (DIN),
        .ADDR  (ADDR),
        .DOUT  (DOUT),
        .W     (W)
    );

    ////////////////////
    // memory model with one cycle of latency on the falling edge
    always @(negedge Clock) begin
        DIN      <= mem[readAddr];
        readAddr <= ADDR[7:0];
        if (W === 1'b1) begin
            mem[ADDR[7:0]] = DOUT;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic wordT signExtend9(input logic [8:0] v);
        return {{7{v[8]}}, v};
    endfunction

    ////////////////////
    // program builder
    function automatic wordT regForm(input opcodeT op, input int rx, input int ry);
        return {op, 1'b0, 3'(rx), 6'b0, 3'(ry)};
    endfunction

    function automatic wordT immForm(input opcodeT op, input int rx, input logic [8:0] imm);
        return {op, 1'b1, 3'(rx), imm};
    endfunction

    function automatic wordT branchWord(input branchCondT cond, input logic [8:0] offset);
        return {opMvt, 1'b0, cond, offset};  // offset from the next word
    endfunction

    task automatic emit(input wordT w);
        mem[progLen] = w;
        progLen++;
    endtask

    task automatic clearMemory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {~8'(i), 8'(i)};  // fill tied to the address
        end
        progLen = 0;
        expAddr.delete();
        expData.delete();
    endtask

    ////////////////////
    // reference instruction set model that fills the expected stores
    function automatic int runReference();
        wordT        rf  [0:7];  // r7 stands for pc
        wordT        img [0:255];
        wordT        ir;
        wordT        opnd;
        wordT        target;
        opcodeT      op;
        logic [16:0] wide;       // carry out on top
        logic [2:0]  rx;
        logic        carry;
        logic        negative;
        logic        zero;
        logic        taken;
        logic        halted;
        int          steps;
        img      = mem;
        halted   = 1'b0;
        steps    = 0;
        carry    = 1'b0;
        negative = 1'b0;
        zero     = 1'b0;
        for (int i = 0; i < 8; i++) begin
            rf[i] = '0;
        end
        while (!halted && steps < maxSteps) begin
            ir    = img[rf[7][7:0]];
            rf[7] = rf[7] + 16'd1;
            steps++;
            op    = opcodeT'(ir[15:13]);
            rx    = ir[11:9];
            opnd  = ir[12] ? signExtend9(ir[8:0]) : rf[ir[2:0]];
            case (op)
                opMv: rf[rx] = opnd;
                opMvt: begin
                    if (ir[12]) begin
                        rf[rx] = {ir[7:0], 8'h00};  // upper byte
                    end else begin
                        case (rx)  // condition field
                            3'd1:    taken = zero;
                            3'd2:    taken = !zero;
                            3'd3:    taken = !carry;
                            3'd4:    taken = carry;
                            3'd5:    taken = !negative;
                            3'd6:    taken = negative;
                            default: taken = 1'b1;
                        endcase
                        target = rf[7] + signExtend9(ir[8:0]);
                        if (taken) begin
                            halted = (target == rf[7] - 16'd1);  // branch to itself
                            rf[7]  = target;
                        end
                    end
                end
                opLd: rf[rx] = img[rf[ir[2:0]][7:0]];
                opSt: begin
                    img[rf[ir[2:0]][7:0]] = rf[rx];
                    expAddr.push_back(rf[ir[2:0]]);
                    expData.push_back(rf[rx]);
                end
                default: begin  // add, sub, and, cmp
                    case (op)
                        opAdd:   wide = {1'b0, rf[rx]} + {1'b0, opnd};
                        opAnd:   wide = {1'b0, rf[rx] & opnd};
                        default: wide = {rf[rx] >= opnd, rf[rx] - opnd};  // carry means no borrow
                    endcase
                    carry    = wide[16];
                    negative = wide[15];
                    zero     = (wide[15:0] == 16'h0000);
                    if (op != opCmp) begin
                        rf[rx] = wide[15:0];
                    end
                end
            endcase
        end
        return steps;
    endfunction

    // halt word, expected stores and a larger cycle budget
    task automatic finishProgram();
        int steps;
        emit(branchWord(brAlways, 9'h1FF));
        haltAddr   = progLen - 1;
        steps      = runReference();
        cycleLimit = cycleLimit + 2 * 6 * steps + resetCycles + 2;
    endtask

    task automatic beginReset();
        @(negedge Clock);
        Run      = 1'b0;
        resetReq = 1'b1;
        @(negedge Clock);
        resetReq = 1'b0;
        clearMemory();
    endtask

    task automatic runAndReport(input int num, input string name);
        int errorsBefore;
        int stores;
        errorsBefore = errorCount;
        stores       = expAddr.size();
        Run          = 1'b1;
        @(negedge Clock);
        checkCount++;
        if (ADDR !== 16'h0000) begin
            $display("Error: ADDR expected 0000, got %h on the first fetch", ADDR);
            errorCount++;
        end
        while (ADDR !== wordT'(haltAddr)) @(negedge Clock);  // halt loop reached
        checkCount++;
        if (expAddr.size() != 0) begin
            $display("test %0d: %0d expected stores never appeared", num, expAddr.size());
            errorCount++;
        end
        Run = 1'b0;
        testCount++;
        $display("test %0d %s: %0d stores, %0d errors", num, name, stores,
                 errorCount - errorsBefore);
    endtask

    ////////////////////
    // store checker with W pulse width and stability
    initial begin
        wordT expA;
        wordT expD;
        wordT seenA;
        wordT seenD;
        forever begin
            @(negedge Clock);
            if (W === 1'b1 && wPrev) begin
                $display("W stayed high for more than one cycle at address %h", ADDR);
                errorCount++;
            end else if (W === 1'b1) begin
                checkCount++;
                if (expAddr.size() == 0) begin
                    $display("store of %h to address %h was not expected", DOUT, ADDR);
                    errorCount++;
                end else begin
                    expA = expAddr.pop_front();
                    expD = expData.pop_front();
                    if (ADDR !== expA) begin
                        $display("Error: ADDR expected %h, got %h", expA, ADDR);
                        errorCount++;
                    end
                    if (DOUT !== expD) begin
                        $display("Error: DOUT expected %h, got %h", expD, DOUT);
                        errorCount++;
                    end
                end
                seenA = ADDR;
                seenD = DOUT;
                #(quarterPeriod);  // look again later in the same cycle
                if (ADDR !== seenA || DOUT !== seenD) begin
                    $display("ADDR or DOUT changed while W was high");
                    errorCount++;
                end
            end
            wPrev = (W === 1'b1);
        end
    end

    // watchdog
    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: no halt reached within %0d cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////
    // tests
    initial begin
        opcodeT      op;
        logic [31:0] pick;

        // test 1 covers reset state and Run gating
        clearMemory();
        emit(immForm(opMv, 0, 9'(nextRand())));
        emit(immForm(opMv, 6, 9'(storeBase)));
        emit(regForm(opSt, 0, 6));
        finishProgram();
        @(posedge arstN);
        repeat (idleCycles) begin
            @(negedge Clock);
            checkCount++;
            if (ADDR !== 16'h0000 || W !== 1'b0) begin
                $display("ADDR left 0000 or W rose while Run was low");
                errorCount++;
            end
        end
        runAndReport(1, "reset and Run");

        // test 2 covers mv and mvt
        beginReset();
        emit(immForm(opMv, 0, 9'(nextRand())));
        emit(regForm(opMv, 1, 0));
        emit(immForm(opMvt, 2, {1'b0, 8'(nextRand())}));
        emit(immForm(opMv, 3, 9'(nextRand())));
        emit(regForm(opMv, 4, 3));
        emit(immForm(opMvt, 5, {1'b0, 8'(nextRand())}));
        for (int r = 0; r < 6; r++) begin
            emit(immForm(opMv, 6, 9'(storeBase + r)));
            emit(regForm(opSt, r, 6));
        end
        finishProgram();
        @(posedge arstN);
        runAndReport(2, "moves");

        // test 3 runs add, sub and and into an accumulator in r0
        beginReset();
        emit(immForm(opMv, 0, 9'(nextRand())));
        emit(immForm(opMvt, 3, {1'b0, 8'(nextRand())}));
        emit(regForm(opAdd, 0, 3));
        for (int k = 0; k < 8; k++) begin
            pick = nextRand();
            op   = (pick % 3 == 0) ? opAdd : (pick % 3 == 1) ? opSub : opAnd;
            emit(immForm(opMv, 1, 9'(nextRand())));
            if (pick[4]) begin
                emit(immForm(op, 0, 9'(nextRand())));
            end else begin
                emit(regForm(op, 0, 1));
            end
            emit(immForm(opMv, 6, 9'(storeBase + k)));
            emit(regForm(opSt, 0, 6));
        end
        finishProgram();
        @(posedge arstN);
        runAndReport(3, "arithmetic");

        // test 4 loads preloaded words and stores them swapped
        beginReset();
        for (int i = 0; i < 8; i++) begin
            mem[dataBase + i] = 16'(nextRand());
        end
        for (int k = 0; k < 3; k++) begin
            emit(immForm(opMv, 5, 9'(dataBase) + 9'(3'(nextRand()))));
            emit(regForm(opLd, 1, 5));
            emit(immForm(opMv, 5, 9'(dataBase) + 9'(3'(nextRand()))));
            emit(regForm(opLd, 2, 5));
            emit(immForm(opMv, 6, 9'(storeBase + 2 * k)));
            emit(regForm(opSt, 2, 6));
            emit(immForm(opMv, 6, 9'(storeBase + 2 * k + 1)));
            emit(regForm(opSt, 1, 6));
        end
        finishProgram();
        @(posedge arstN);
        runAndReport(4, "load and store");

        // test 5 tries every condition once after cmp and once after add
        beginReset();
        for (int k = 0; k < 16; k++) begin
            emit(immForm(opMv, 1, 9'(nextRand())));
            emit(immForm((k < 8) ? opCmp : opAdd, 1, 9'(nextRand())));
            emit(branchWord(branchCondT'(3'(k)), 9'd2));  // to the taken marker
            emit(immForm(opMv, 2, 9'h050 + 9'(k)));       // not taken
            emit(branchWord(brAlways, 9'd1));
            emit(immForm(opMv, 2, 9'h0A0 + 9'(k)));       // taken
            emit(immForm(opMv, 6, 9'(storeBase + k)));
            emit(regForm(opSt, 2, 6));
        end
        finishProgram();
        @(posedge arstN);
        runAndReport(5, "compare and branch");

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
    parameter int resetCycles = 16
) (
    input  wire  resetReq,  // rising edge starts another reset
    output logic Clock,
    output logic arstN
);

    localparam int halfPeriod = 50;  // 100 ns clock

    initial begin
        Clock = 1'b0;
        forever #(halfPeriod) Clock = ~Clock;
    end

    // reset from time zero, then again on each request
    initial begin
        arstN = 1'b0;
        forever begin
            repeat (resetCycles) @(negedge Clock);
            arstN = 1'b1;  // released on a falling edge
            @(posedge resetReq);
            arstN = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/cpuTop.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTop import cpuPkg::*; (
    input  wire       Clock,
    input  wire       arstN,
    input  wire       Run,
    input  wire wordT DIN,
    output wordT      ADDR,
    output wordT      DOUT,
    output logic      W
);

    wordT     bus;   // internal processor bus
    regArrayT regs;
    wordT     pc;
    wordT     g;     // ALU result register

    ctrlIf ctrl ();

    ////////////////////
    // sequencer and datapath
    controlFsm uFsm (
        .Clock (Clock),
        .arstN (arstN),
        .Run   (Run),
        .ctrl  (ctrl.seq)
    );

    registerFile uRegs (
        .Clock (Clock),
        .arstN (arstN),
        .ctrl  (ctrl.regs),
        .bus   (bus),
        .regs  (regs),
        .pc    (pc)
    );

    aluFlags uAlu (
        .Clock (Clock),
        .arstN (arstN),
        .ctrl  (ctrl.alu),
        .bus   (bus),
        .g     (g)
    );

    busDatapath uBus (
        .Clock (Clock),
        .arstN (arstN),
        .ctrl  (ctrl.dp),
        .regs  (regs),
        .pc    (pc),
        .g     (g),
        .DIN   (DIN),
        .bus   (bus),
        .ADDR  (ADDR),
        .DOUT  (DOUT),
        .W     (W)
    );

endmodule

`default_nettype wire

// File: verilog/busDatapath.sv
`timescale 1ns/100ps
`default_nettype none

module busDatapath import cpuPkg::*; (
    input  wire           Clock,
    input  wire           arstN,
    ctrlIf.dp             ctrl,
    input  wire regArrayT regs,
    input  wire wordT     pc,
    input  wire wordT     g,
    input  wire wordT     DIN,
    output wordT          bus,
    output wordT          ADDR,
    output wordT          DOUT,
    output logic          W
);

    wordT irReg;
    wordT immSext;   // 9-bit immediate, sign extended
    wordT immHigh;   // 8-bit immediate in the upper byte

    ////////////////////
    // immediate formatting
    assign immSext = {{(wordWidth - immWidth){irReg[immWidth-1]}}, irReg[immWidth-1:0]};
    assign immHigh = {irReg[wordWidth/2-1:0], {(wordWidth/2){1'b0}}};

    // internal bus mux
    always_comb begin
        case (ctrl.busSel)
            selR0, selR1, selR2, selR3, selR4, selR5, selR6:
                bus = regs[ctrl.busSel[2:0]];
            selPc:      bus = pc;
            selG:       bus = g;
            selImmSext: bus = immSext;
            selImmHigh: bus = immHigh;
            selDin:     bus = DIN;
            default:    bus = '0;
        endcase
    end

    ////////////////////
    // IR, ADDR, DOUT, W
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            irReg <= '0;
        end else if (ctrl.irLoad) begin
            irReg <= DIN;  // straight from memory, not the bus
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            ADDR <= '0;
            DOUT <= '0;
        end else begin
            if (ctrl.addrLoad) begin
                ADDR <= bus;
            end
            if (ctrl.doutLoad) begin
                DOUT <= bus;
            end
        end
    end

    // write strobe, lines up with the new DOUT
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            W <= 1'b0;
        end else begin
            W <= ctrl.wNext;
        end
    end

    assign ctrl.ir = irReg;

endmodule

`default_nettype wire

// File: verilog/aluFlags.sv
`timescale 1ns/100ps
`default_nettype none

module aluFlags import cpuPkg::*; (
    input  wire       Clock,
    input  wire       arstN,
    ctrlIf.alu        ctrl,
    input  wire wordT bus,
    output wordT      g
);

    wordT               aReg;    // first operand
    logic [wordWidth:0] aluRes;  // carry out on top
    flagsT              flagsD;
    flagsT              flagsQ;

    ////////////////////
    // add, sub, and
    always_comb begin
        case (ctrl.aluOp)
            aluSub:  aluRes = {1'b0, aReg} + {1'b0, ~bus} + 1'b1;  // two's complement
            aluAnd:  aluRes = {1'b0, aReg & bus};                  // never carries
            default: aluRes = {1'b0, aReg} + {1'b0, bus};
        endcase
    end

    assign flagsD.carry    = aluRes[wordWidth];
    assign flagsD.negative = aluRes[wordWidth-1];
    assign flagsD.zero     = (aluRes[wordWidth-1:0] == '0);

    // operand A
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            aReg <= '0;
        end else if (ctrl.aLoad) begin
            aReg <= bus;
        end
    end

    // result G, skipped by cmp
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            g <= '0;
        end else if (ctrl.gLoad) begin
            g <= aluRes[wordWidth-1:0];
        end
    end

    ////////////////////
    // flag register
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            flagsQ <= '0;
        end else if (ctrl.flagLoad) begin
            flagsQ <= flagsD;
        end
    end

    assign ctrl.flags = flagsQ;

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile import cpuPkg::*; (
    input  wire       Clock,
    input  wire       arstN,
    ctrlIf.regs       ctrl,
    input  wire wordT bus,
    output regArrayT  regs,
    output wordT      pc
);

    logic [numGpRegs-1:0] regEn;    // one write enable per register
    logic                 pcWrite;  // rX = 7 targets pc

    ////////////////////
    // write decode
    always_comb begin
        for (int i = 0; i < numGpRegs; i++) begin
            regEn[i] = ctrl.regWrite && (ctrl.rX == 3'(i));
        end
    end

    assign pcWrite = ctrl.regWrite && (ctrl.rX == 3'(numGpRegs));

    // general registers r0 to r6
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            regs <= '0;
        end else begin
            for (int i = 0; i < numGpRegs; i++) begin
                if (regEn[i]) begin
                    regs[i] <= bus;
                end
            end
        end
    end

    ////////////////////
    // program counter
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (ctrl.pcLoad || pcWrite) begin
            pc <= bus;  // load wins over increment
        end else if (ctrl.pcIncr) begin
            pc <= pc + wordT'(1);
        end
    end

endmodule

`default_nettype wire

// File: verilog/controlFsm.sv
`timescale 1ns/100ps
`default_nettype none

module controlFsm import cpuPkg::*; (
    input  wire  Clock,
    input  wire  arstN,
    input  wire  Run,
    ctrlIf.seq   ctrl
);

    tStepT      stepQ;
    tStepT      stepD;
    opcodeT     opcode;
    logic       immFlag;
    logic [2:0] rXField;
    logic [2:0] rYField;
    branchCondT cond;
    busSelT     operandSel;  // second ALU or move operand
    logic       done;        // last step of the instruction
    logic       condMet;

    // register number maps straight onto the select code, 7 lands on pc
    function automatic busSelT regSel(input logic [2:0] r);
        return busSelT'({1'b0, r});
    endfunction

    ////////////////////
    // instruction decode
    assign opcode     = opcodeT'(ctrl.ir[opcodeMsb -: $bits(opcodeT)]);
    assign immFlag    = ctrl.ir[immBit];
    assign rXField    = ctrl.ir[rXLsb +: 3];
    assign rYField    = ctrl.ir[2:0];
    assign cond       = branchCondT'(rXField);  // branches reuse the rX slot
    assign operandSel = immFlag ? selImmSext : regSel(rYField);
    assign ctrl.rX    = rXField;

    // branch test on the current flags
    always_comb begin
        case (cond)
            brEq:    condMet = ctrl.flags.zero;
            brNe:    condMet = !ctrl.flags.zero;
            brCc:    condMet = !ctrl.flags.carry;
            brCs:    condMet = ctrl.flags.carry;
            brPl:    condMet = !ctrl.flags.negative;
            brMi:    condMet = ctrl.flags.negative;
            default: condMet = 1'b1;  // brAlways and brAlways2
        endcase
    end

    ////////////////////
    // time step sequencing
    always_comb begin
        case (stepQ)
            stepT0:  stepD = Run ? stepT1 : stepT0;  // hold until Run
            stepT1:  stepD = stepT2;
            stepT2:  stepD = stepT3;
            stepT3:  stepD = done ? stepT0 : stepT4;
            stepT4:  stepD = done ? stepT0 : stepT5;
            default: stepD = stepT0;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            stepQ <= stepT0;
        end else begin
            stepQ <= stepD;
        end
    end

    ////////////////////
    // strobes per step
    always_comb begin
        ctrl.busSel   = selPc;
        ctrl.aluOp    = aluAdd;
        ctrl.aLoad    = 1'b0;
        ctrl.gLoad    = 1'b0;
        ctrl.flagLoad = 1'b0;
        ctrl.irLoad   = 1'b0;
        ctrl.addrLoad = 1'b0;
        ctrl.doutLoad = 1'b0;
        ctrl.wNext    = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.pcIncr   = 1'b0;
        ctrl.pcLoad   = 1'b0;
        done          = 1'b0;
        case (stepQ)
            stepT0: begin  // fetch address from pc
                ctrl.busSel   = selPc;
                ctrl.addrLoad = 1'b1;
                ctrl.pcIncr   = Run;
            end
            stepT1: ;  // memory latency
            stepT2: ctrl.irLoad = 1'b1;  // DIN holds the instruction now
            stepT3: begin
                case (opcode)
                    opMv: begin
                        ctrl.busSel   = operandSel;
                        ctrl.regWrite = 1'b1;
                        done          = 1'b1;
                    end
                    opMvt: begin
                        if (immFlag) begin
                            ctrl.busSel   = selImmHigh;
                            ctrl.regWrite = 1'b1;
                            done          = 1'b1;
                        end else begin  // branch, pc already points past it
                            ctrl.busSel = selPc;
                            ctrl.aLoad  = 1'b1;
                        end
                    end
                    opAdd, opSub, opAnd, opCmp: begin
                        ctrl.busSel = regSel(rXField);
                        ctrl.aLoad  = 1'b1;
                    end
                    default: begin  // ld and st address from rY
                        ctrl.busSel   = regSel(rYField);
                        ctrl.addrLoad = 1'b1;
                    end
                endcase
            end
            stepT4: begin
                case (opcode)
                    opMvt: begin  // target = A + offset
                        ctrl.busSel = selImmSext;
                        ctrl.gLoad  = 1'b1;
                    end
                    opAdd, opSub, opAnd: begin
                        ctrl.busSel   = operandSel;
                        ctrl.aluOp    = (opcode == opAdd) ? aluAdd :
                                        (opcode == opSub) ? aluSub : aluAnd;
                        ctrl.gLoad    = 1'b1;
                        ctrl.flagLoad = 1'b1;
                    end
                    opCmp: begin
                        ctrl.busSel   = operandSel;
                        ctrl.aluOp    = aluSub;  // flags only, G untouched
                        ctrl.flagLoad = 1'b1;
                        done          = 1'b1;
                    end
                    opSt: begin
                        ctrl.busSel   = regSel(rXField);
                        ctrl.doutLoad = 1'b1;
                        ctrl.wNext    = 1'b1;
                    end
                    default: ;  // ld waits on memory
                endcase
            end
            stepT5: begin
                done = 1'b1;
                case (opcode)
                    opMvt: begin
                        ctrl.busSel = selG;
                        ctrl.pcLoad = condMet;
                    end
                    opAdd, opSub, opAnd: begin
                        ctrl.busSel   = selG;
                        ctrl.regWrite = 1'b1;
                    end
                    opLd: begin
                        ctrl.busSel   = selDin;
                        ctrl.regWrite = 1'b1;
                    end
                    default: ;  // st just finishes
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/ctrlIf.sv
`timescale 1ns/100ps
`default_nettype none

interface ctrlIf import cpuPkg::*; ();

    busSelT     busSel;     // internal bus source
    aluOpT      aluOp;
    // load strobes, one cycle each
    logic       aLoad;
    logic       gLoad;
    logic       flagLoad;
    logic       irLoad;
    logic       addrLoad;
    logic       doutLoad;
    logic       wNext;      // W rises next cycle
    logic       regWrite;   // bus into rX
    logic [2:0] rX;
    logic       pcIncr;
    logic       pcLoad;     // branch taken
    // back to the sequencer
    wordT       ir;
    flagsT      flags;

    modport seq (
        output busSel, aluOp, aLoad, gLoad, flagLoad, irLoad, addrLoad, doutLoad,
               wNext, regWrite, rX, pcIncr, pcLoad,
        input  ir, flags
    );
    modport dp   (input busSel, irLoad, addrLoad, doutLoad, wNext, output ir);
    modport alu  (input aluOp, aLoad, gLoad, flagLoad, output flags);
    modport regs (input regWrite, rX, pcIncr, pcLoad);

endinterface

`default_nettype wire

// File: verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

    ////////////////////
    // widths
    localparam int wordWidth = 16;  // data and address
    localparam int numGpRegs = 7;   // r0 to r6, pc kept apart

    // instruction layout III M XXX DDDDDDDDD
    localparam int opcodeMsb = 15;
    localparam int immBit    = 12;  // 1 selects the immediate operand
    localparam int rXLsb     = 9;   // also holds the branch condition
    localparam int immWidth  = 9;

    typedef logic [wordWidth-1:0] wordT;
    typedef wordT [numGpRegs-1:0] regArrayT;

    ////////////////////
    // encodings
    typedef enum logic [2:0] {
        opMv  = 3'b000,
        opMvt = 3'b001,   // M = 0 is a branch
        opAdd = 3'b010,
        opSub = 3'b011,
        opLd  = 3'b100,
        opSt  = 3'b101,
        opAnd = 3'b110,
        opCmp = 3'b111    // shift and rotate forms not decoded
    } opcodeT;

    typedef enum logic [2:0] {
        brAlways, brEq, brNe, brCc, brCs, brPl, brMi,
        brAlways2         // old link code, now plain always
    } branchCondT;

    // bus sources, r0 to r6 match the register number
    typedef enum logic [3:0] {
        selR0, selR1, selR2, selR3, selR4, selR5, selR6,
        selPc, selG, selImmSext, selImmHigh, selDin
    } busSelT;

    typedef enum logic [2:0] {
        stepT0, stepT1, stepT2, stepT3, stepT4, stepT5
    } tStepT;

    typedef enum logic [1:0] {
        aluAdd, aluSub, aluAnd
    } aluOpT;

    typedef struct packed {
        logic carry;
        logic negative;
        logic zero;
    } flagsT;

endpackage

`default_nettype wire
